//--- core_pkg.sv
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
    } fetch_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_nor,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_b,
        br_bl,
        br_jirl
    } br_kind_e;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        alu_op_e               alu_op;
        logic [xlen-1:0]       alu_src1;
        logic [xlen-1:0]       alu_src2;
        logic [xlen-1:0]       rj_value;
        logic [xlen-1:0]       rkd_value;
        br_kind_e              br_kind;
        logic [xlen-1:0]       br_offs;
        logic                  rf_we;
        logic [reg_addr_w-1:0] rf_waddr;
    } decoded_t;

    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } wb_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        wb_t             wb;
    } retire_t;

    typedef struct packed {
        logic            taken;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

//--- instr_queue.sv
`timescale 1ns/1ps

module instr_queue
    import core_pkg::*;
#(
    parameter int queue_depth = 4
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      fetch_valid,
    input  fetch_t    fetch,
    output logic      fetch_credit,
    input  logic      pop,
    input  redirect_t redirect,
    output logic      head_valid,
    output fetch_t    head
);
    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    fetch_t           mem [queue_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // a push racing a redirect is on the wrong path
    assign push       = fetch_valid & ~redirect.taken;
    assign do_pop     = pop & head_valid;
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    // sender resets its own count on redirect
    assign fetch_credit = do_pop & ~redirect.taken;

    always_ff @(posedge clk) begin
        if (!resetn || redirect.taken) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + cnt_w'(push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch;
        end
    end

    // sender must respect its credits
    a_no_push_when_full: assert property (@(posedge clk) disable iff (!resetn)
        push |-> (count != cnt_w'(queue_depth)));

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      head_valid,
    input  fetch_t    head,
    output logic      pop,
    input  logic      hold,
    input  redirect_t redirect,
    input  wb_t       ex_fwd,
    input  wb_t       wb,
    output logic      dec_valid,
    output decoded_t  dec
);
    logic [xlen-1:0]       rf [32];
    logic [xlen-1:0]       inst;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rj;
    logic [reg_addr_w-1:0] rkd_addr;
    logic [xlen-1:0]       si12;
    logic [xlen-1:0]       ui12;
    logic [xlen-1:0]       offs16;
    logic [xlen-1:0]       offs26;
    logic [xlen-1:0]       imm;
    logic [xlen-1:0]       rj_value;
    logic [xlen-1:0]       rkd_value;
    alu_op_e               alu_op;
    br_kind_e              br_kind;
    logic                  writes_rd;
    logic                  link;
    logic                  is_u20;
    logic                  is_pcaddu12i;
    logic                  is_ui12;
    logic                  src1_is_pc;
    logic                  src2_is_imm;
    logic [reg_addr_w-1:0] dest;
    decoded_t              dec_next;

    function automatic logic [xlen-1:0] read_operand(
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       rf_value,
        input wb_t                   fwd,
        input wb_t                   w
    );
        if (addr == '0) begin
            return '0;
        end else if (fwd.we && fwd.waddr == addr) begin
            return fwd.wdata;
        end else if (w.we && w.waddr == addr) begin
            return w.wdata;
        end
        return rf_value;
    endfunction

    always_ff @(posedge clk) begin
        if (wb.we && wb.waddr != '0) begin
            rf[wb.waddr] <= wb.wdata;
        end
    end

    assign inst   = head.inst;
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign ui12   = {20'b0, inst[21:10]};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    // alu op from the opcode fields; anything unmatched writes nothing
    always_comb begin
        alu_op    = alu_add;
        writes_rd = 1'b1;
        casez (inst[31:15])
            {6'h00, 4'h0, 2'h1, 5'h00}, {6'h00, 4'ha, 7'b???????},
            {6'h07, 1'b0, 10'b??????????}, {6'h13, 11'b???????????},
            {6'h15, 11'b???????????}: alu_op = alu_add;
            {6'h00, 4'h0, 2'h1, 5'h02}: alu_op = alu_sub;
            {6'h00, 4'h0, 2'h1, 5'h04}, {6'h00, 4'h8, 7'b???????}: alu_op = alu_slt;
            {6'h00, 4'h0, 2'h1, 5'h05}, {6'h00, 4'h9, 7'b???????}: alu_op = alu_sltu;
            {6'h00, 4'h0, 2'h1, 5'h08}: alu_op = alu_nor;
            {6'h00, 4'h0, 2'h1, 5'h09}, {6'h00, 4'hd, 7'b???????}: alu_op = alu_and;
            {6'h00, 4'h0, 2'h1, 5'h0a}, {6'h00, 4'he, 7'b???????}: alu_op = alu_or;
            {6'h00, 4'h0, 2'h1, 5'h0b}, {6'h00, 4'hf, 7'b???????}: alu_op = alu_xor;
            {6'h00, 4'h0, 2'h1, 5'h0e}, {6'h00, 4'h1, 2'h0, 5'h01}: alu_op = alu_sll;
            {6'h00, 4'h0, 2'h1, 5'h0f}, {6'h00, 4'h1, 2'h0, 5'h09}: alu_op = alu_srl;
            {6'h00, 4'h0, 2'h1, 5'h10}, {6'h00, 4'h1, 2'h0, 5'h11}: alu_op = alu_sra;
            {6'h05, 1'b0, 10'b??????????}: alu_op = alu_lui;
            default: writes_rd = 1'b0;
        endcase
    end

    always_comb begin
        case (inst[31:26])
            6'h13:   br_kind = br_jirl;
            6'h14:   br_kind = br_b;
            6'h15:   br_kind = br_bl;
            6'h16:   br_kind = br_beq;
            6'h17:   br_kind = br_bne;
            6'h18:   br_kind = br_blt;
            6'h19:   br_kind = br_bge;
            6'h1a:   br_kind = br_bltu;
            6'h1b:   br_kind = br_bgeu;
            default: br_kind = br_none;
        endcase
    end

    assign link         = (br_kind == br_bl) || (br_kind == br_jirl);
    assign is_pcaddu12i = (inst[31:26] == 6'h07) && !inst[25];
    assign is_u20       = is_pcaddu12i || ((inst[31:26] == 6'h05) && !inst[25]);
    assign is_ui12      = (inst[31:26] == 6'h00) && (inst[25:22] >= 4'hd);
    assign src1_is_pc   = link || is_pcaddu12i;
    assign src2_is_imm  = (inst[31:20] != 12'h001);
    assign imm = link    ? 32'd4 :
                 is_u20  ? {inst[24:5], 12'b0} :
                 is_ui12 ? ui12 : si12;

    // conditional branches compare rj against rd
    assign rkd_addr  = (br_kind inside {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu}) ?
                       rd : inst[14:10];
    assign rj_value  = read_operand(rj, rf[rj], ex_fwd, wb);
    assign rkd_value = read_operand(rkd_addr, rf[rkd_addr], ex_fwd, wb);
    assign dest      = (br_kind == br_bl) ? reg_addr_w'(1) : rd;

    assign dec_next = '{
        pc:        head.pc,
        alu_op:    alu_op,
        alu_src1:  src1_is_pc ? head.pc : rj_value,
        alu_src2:  src2_is_imm ? imm : rkd_value,
        rj_value:  rj_value,
        rkd_value: rkd_value,
        br_kind:   br_kind,
        br_offs:   ((br_kind == br_b) || (br_kind == br_bl)) ? offs26 : offs16,
        rf_we:     writes_rd && (dest != '0),
        rf_waddr:  dest
    };

    assign pop = head_valid & ~hold;

    always_ff @(posedge clk) begin
        if (!resetn || redirect.taken) begin
            dec_valid <= 1'b0;
        end else if (!hold) begin
            dec_valid <= head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            dec <= dec_next;
        end
    end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      dec_valid,
    input  decoded_t  dec,
    input  logic      hold,
    output wb_t       ex_fwd,
    output redirect_t redirect,
    output logic      ex_valid,
    output retire_t   ex_res
);
    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] target;
    logic            rj_eq_rkd;
    logic            lt_s;
    logic            lt_u;
    logic            br_taken;
    logic            redirect_taken_q;
    logic [xlen-1:0] redirect_target_q;

    always_comb begin
        case (dec.alu_op)
            alu_add:  alu_res = dec.alu_src1 + dec.alu_src2;
            alu_sub:  alu_res = dec.alu_src1 - dec.alu_src2;
            alu_slt:  alu_res = xlen'($signed(dec.alu_src1) < $signed(dec.alu_src2));
            alu_sltu: alu_res = xlen'(dec.alu_src1 < dec.alu_src2);
            alu_and:  alu_res = dec.alu_src1 & dec.alu_src2;
            alu_nor:  alu_res = ~(dec.alu_src1 | dec.alu_src2);
            alu_or:   alu_res = dec.alu_src1 | dec.alu_src2;
            alu_xor:  alu_res = dec.alu_src1 ^ dec.alu_src2;
            alu_sll:  alu_res = dec.alu_src1 << dec.alu_src2[4:0];
            alu_srl:  alu_res = dec.alu_src1 >> dec.alu_src2[4:0];
            alu_sra:  alu_res = $signed(dec.alu_src1) >>> dec.alu_src2[4:0];
            alu_lui:  alu_res = dec.alu_src2;
            default:  alu_res = '0;
        endcase
    end

    assign rj_eq_rkd = (dec.rj_value == dec.rkd_value);
    assign lt_s      = $signed(dec.rj_value) < $signed(dec.rkd_value);
    assign lt_u      = dec.rj_value < dec.rkd_value;

    always_comb begin
        case (dec.br_kind)
            br_beq:                 br_taken = rj_eq_rkd;
            br_bne:                 br_taken = !rj_eq_rkd;
            br_blt:                 br_taken = lt_s;
            br_bge:                 br_taken = !lt_s;
            br_bltu:                br_taken = lt_u;
            br_bgeu:                br_taken = !lt_u;
            br_b, br_bl, br_jirl:   br_taken = 1'b1;
            default:                br_taken = 1'b0;
        endcase
    end

    assign target = ((dec.br_kind == br_jirl) ? dec.rj_value : dec.pc) + dec.br_offs;

    // unregistered result for the bypass into decode
    assign ex_fwd   = '{we: dec_valid & dec.rf_we, waddr: dec.rf_waddr, wdata: alu_res};
    assign redirect = '{taken: redirect_taken_q, target: redirect_target_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid         <= 1'b0;
            redirect_taken_q <= 1'b0;
        end else begin
            // the slot behind a taken branch is wrong path
            redirect_taken_q <= dec_valid & ~hold & ~redirect_taken_q & br_taken;
            if (!hold) begin
                ex_valid <= dec_valid & ~redirect_taken_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        redirect_target_q <= target;
        if (!hold) begin
            ex_res <= '{pc: dec.pc, wb: '{we: dec.rf_we, waddr: dec.rf_waddr, wdata: alu_res}};
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (!resetn)
        redirect.taken |-> (redirect.target[1:0] == 2'b00));

endmodule

//--- retire_stage.sv
`timescale 1ns/1ps

module retire_stage
    import core_pkg::*;
#(
    parameter int retire_credits = 2
) (
    input  logic    clk,
    input  logic    resetn,
    input  logic    ex_valid,
    input  retire_t ex_res,
    input  logic    retire_credit,
    output logic    hold,
    output wb_t     wb,
    output logic    retire_valid,
    output retire_t retire
);
    // one spare count so an overflow is still visible
    localparam int cnt_w = $clog2(retire_credits + 2);

    logic             full;
    logic             accept;
    logic [cnt_w-1:0] credit_cnt;
    retire_t          ret_q;

    assign retire_valid = full & (credit_cnt != '0);
    assign hold         = full & (credit_cnt == '0);
    assign accept       = ex_valid & ~hold;
    assign retire       = ret_q;

    // commit as the result enters the retire register
    // keeps it visible to decode two stages back
    assign wb = '{
        we:    accept & ex_res.wb.we,
        waddr: ex_res.wb.waddr,
        wdata: ex_res.wb.wdata
    };

    always_ff @(posedge clk) begin
        if (!resetn) begin
            full       <= 1'b0;
            credit_cnt <= cnt_w'(retire_credits);
        end else begin
            if (accept) begin
                full <= 1'b1;
            end else if (retire_valid) begin
                full <= 1'b0;
            end
            credit_cnt <= credit_cnt - cnt_w'(retire_valid) + cnt_w'(retire_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ret_q <= ex_res;
        end
    end

    // receiver never returns more than it was given
    a_credit_bound: assert property (@(posedge clk) disable iff (!resetn)
        credit_cnt <= cnt_w'(retire_credits));

endmodule

//--- core_top.sv
`timescale 1ns/1ps

module core_top
    import core_pkg::*;
#(
    parameter int queue_depth    = 4,
    parameter int retire_credits = 2
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      fetch_valid,
    input  fetch_t    fetch,
    output logic      fetch_credit,
    output logic      retire_valid,
    output retire_t   retire,
    input  logic      retire_credit,
    output redirect_t redirect
);
    logic     head_valid;
    fetch_t   head;
    logic     pop;
    logic     hold;
    logic     dec_valid;
    decoded_t dec;
    wb_t      ex_fwd;
    wb_t      wb;
    logic     ex_valid;
    retire_t  ex_res;

    instr_queue #(
        .queue_depth (queue_depth)
    ) u_instr_queue (
        .clk          (clk),
        .resetn       (resetn),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .fetch_credit (fetch_credit),
        .pop          (pop),
        .redirect     (redirect),
        .head_valid   (head_valid),
        .head         (head)
    );

    decode_stage u_decode_stage (
        .clk        (clk),
        .resetn     (resetn),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .hold       (hold),
        .redirect   (redirect),
        .ex_fwd     (ex_fwd),
        .wb         (wb),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    execute_stage u_execute_stage (
        .clk       (clk),
        .resetn    (resetn),
        .dec_valid (dec_valid),
        .dec       (dec),
        .hold      (hold),
        .ex_fwd    (ex_fwd),
        .redirect  (redirect),
        .ex_valid  (ex_valid),
        .ex_res    (ex_res)
    );

    retire_stage #(
        .retire_credits (retire_credits)
    ) u_retire_stage (
        .clk           (clk),
        .resetn        (resetn),
        .ex_valid      (ex_valid),
        .ex_res        (ex_res),
        .retire_credit (retire_credit),
        .hold          (hold),
        .wb            (wb),
        .retire_valid  (retire_valid),
        .retire        (retire)
    );

endmodule

//--- tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic logic [31:0] three_reg(input logic [16:0] op, input logic [4:0] rd,
                                          input logic [4:0] rj, input logic [4:0] rk);
    return {op, rk, rj, rd};
endfunction

function automatic logic [31:0] reg_imm(input logic [9:0] op, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [11:0] imm);
    return {op, imm, rj, rd};
endfunction

function automatic logic [31:0] upper_imm(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [19:0] imm);
    return {op, imm, rd};
endfunction

function automatic logic [31:0] cond_branch(input logic [5:0] op, input logic [4:0] rj,
                                            input logic [4:0] rd, input logic [15:0] words);
    return {op, words, rj, rd};
endfunction

function automatic logic [31:0] jump26(input logic [5:0] op, input logic [25:0] words);
    return {op, words[15:0], words[25:16]};
endfunction

// runs one instruction of the ISA on model_rf and returns what should retire
function automatic retire_t ref_exec(input logic [31:0] pc, input logic [31:0] inst,
                                     output logic taken, output logic [31:0] next_pc);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] res;
    logic [31:0] sext12;
    logic [31:0] off16;
    logic [31:0] off26;
    logic [4:0]  rd;
    logic        we;
    retire_t     r;
    rd      = inst[4:0];
    a       = model_rf[inst[9:5]];
    b       = model_rf[inst[14:10]];
    d       = model_rf[rd];
    sext12  = {{20{inst[21]}}, inst[21:10]};
    off16   = {{14{inst[25]}}, inst[25:10], 2'b00};
    off26   = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    we      = 1'b1;
    res     = '0;
    taken   = 1'b0;
    next_pc = pc + 32'd4;
    case (inst[31:15])
        17'h20:  res = a + b;
        17'h22:  res = a - b;
        17'h24:  res = {31'b0, $signed(a) < $signed(b)};
        17'h25:  res = {31'b0, a < b};
        17'h28:  res = ~(a | b);
        17'h29:  res = a & b;
        17'h2a:  res = a | b;
        17'h2b:  res = a ^ b;
        17'h2e:  res = a << b[4:0];
        17'h2f:  res = a >> b[4:0];
        17'h30:  res = $signed(a) >>> b[4:0];
        17'h81:  res = a << inst[14:10];
        17'h89:  res = a >> inst[14:10];
        17'h91:  res = $signed(a) >>> inst[14:10];
        default: we = 1'b0;
    endcase
    if (!we) begin
        we = 1'b1;
        case (inst[31:22])
            10'h008: res = {31'b0, $signed(a) < $signed(sext12)};
            10'h009: res = {31'b0, a < sext12};
            10'h00a: res = a + sext12;
            10'h00d: res = a & {20'b0, inst[21:10]};
            10'h00e: res = a | {20'b0, inst[21:10]};
            10'h00f: res = a ^ {20'b0, inst[21:10]};
            default: we = 1'b0;
        endcase
    end
    if (!we) begin
        we = 1'b1;
        case (inst[31:25])
            7'h0a:   res = {inst[24:5], 12'b0};
            7'h0e:   res = pc + {inst[24:5], 12'b0};
            default: we = 1'b0;
        endcase
    end
    if (!we) begin
        taken = 1'b1;
        case (inst[31:26])
            6'h13: begin
                next_pc = a + off16;
                res     = pc + 32'd4;
                we      = 1'b1;
            end
            6'h14:   next_pc = pc + off26;
            6'h15: begin
                next_pc = pc + off26;
                res     = pc + 32'd4;
                we      = 1'b1;
                rd      = 5'd1;
            end
            6'h16:   taken = (a == d);
            6'h17:   taken = (a != d);
            6'h18:   taken = $signed(a) < $signed(d);
            6'h19:   taken = !($signed(a) < $signed(d));
            6'h1a:   taken = a < d;
            6'h1b:   taken = !(a < d);
            // undecodable word retires as a no-op
            default: taken = 1'b0;
        endcase
        if (inst[31:26] >= 6'h16 && inst[31:26] <= 6'h1b && taken) begin
            next_pc = pc + off16;
        end
    end
    r.pc       = pc;
    r.wb.we    = we && (rd != 5'd0);
    r.wb.waddr = rd;
    r.wb.wdata = res;
    if (r.wb.we) begin
        model_rf[rd] = res;
    end
    return r;
endfunction

task automatic load_program();
    int i;
    // distinct undecodable filler in every word
    for (i = 0; i < prog_words; i++) begin
        prog[i] = 32'hfc00_0000 | i;
    end
    prog[0]  = upper_imm(7'h0a, 5'd1, 20'h12345);
    prog[1]  = reg_imm(10'h00e, 5'd1, 5'd1, 12'h678);
    prog[2]  = reg_imm(10'h00a, 5'd2, 5'd0, 12'hffb);
    prog[3]  = three_reg(17'h20, 5'd3, 5'd1, 5'd2);
    prog[4]  = three_reg(17'h22, 5'd4, 5'd3, 5'd1);
    prog[5]  = three_reg(17'h24, 5'd5, 5'd2, 5'd1);
    prog[6]  = three_reg(17'h25, 5'd6, 5'd2, 5'd1);
    prog[7]  = three_reg(17'h28, 5'd7, 5'd1, 5'd2);
    prog[8]  = three_reg(17'h29, 5'd8, 5'd1, 5'd2);
    prog[9]  = three_reg(17'h2a, 5'd9, 5'd8, 5'd7);
    prog[10] = three_reg(17'h2b, 5'd10, 5'd9, 5'd1);
    prog[11] = reg_imm(10'h00a, 5'd11, 5'd0, 12'd36);
    prog[12] = three_reg(17'h2e, 5'd12, 5'd1, 5'd11);
    prog[13] = three_reg(17'h2f, 5'd13, 5'd2, 5'd11);
    prog[14] = three_reg(17'h30, 5'd14, 5'd2, 5'd11);
    prog[15] = reg_imm(10'h008, 5'd15, 5'd2, 12'hffc);
    prog[16] = reg_imm(10'h009, 5'd16, 5'd2, 12'h7ff);
    prog[17] = reg_imm(10'h00d, 5'd17, 5'd2, 12'hfff);
    prog[18] = reg_imm(10'h00f, 5'd18, 5'd1, 12'h800);
    prog[19] = three_reg(17'h81, 5'd19, 5'd1, 5'd4);
    prog[20] = three_reg(17'h89, 5'd20, 5'd2, 5'd31);
    prog[21] = three_reg(17'h91, 5'd21, 5'd2, 5'd1);
    prog[22] = upper_imm(7'h0e, 5'd22, 20'h00001);
    prog[23] = cond_branch(6'h16, 5'd1, 5'd1, 16'd2);
    prog[24] = reg_imm(10'h00a, 5'd23, 5'd0, 12'd1);
    prog[25] = cond_branch(6'h17, 5'd1, 5'd1, 16'd5);
    prog[26] = cond_branch(6'h18, 5'd2, 5'd1, 16'd2);
    prog[27] = reg_imm(10'h00a, 5'd23, 5'd0, 12'd2);
    prog[28] = cond_branch(6'h19, 5'd2, 5'd1, 16'd9);
    prog[29] = cond_branch(6'h1a, 5'd2, 5'd1, 16'd9);
    prog[30] = cond_branch(6'h1b, 5'd2, 5'd1, 16'd2);
    prog[31] = reg_imm(10'h00a, 5'd23, 5'd0, 12'd3);
    prog[32] = jump26(6'h15, 26'd4);
    prog[33] = reg_imm(10'h00a, 5'd24, 5'd0, 12'd7);
    prog[34] = jump26(6'h14, 26'd4);
    prog[35] = reg_imm(10'h00a, 5'd23, 5'd0, 12'd4);
    prog[36] = reg_imm(10'h00a, 5'd25, 5'd1, 12'd0);
    prog[37] = cond_branch(6'h13, 5'd1, 5'd26, 16'd0);
    prog[38] = three_reg(17'h20, 5'd27, 5'd24, 5'd26);
endtask

`endif

//--- tb_core.sv
`timescale 1ns/1ps

module tb_core
    import core_pkg::*;
();
    localparam int queue_depth    = 4;
    localparam int retire_credits = 2;
    localparam int prog_words     = 64;
    localparam int end_word       = 40;

    logic      clk;
    logic      resetn;
    logic      fetch_valid;
    fetch_t    fetch;
    logic      fetch_credit;
    logic      retire_valid;
    retire_t   retire;
    logic      retire_credit;
    redirect_t redirect;

    logic [31:0] prog [prog_words];
    logic [31:0] model_rf [32];
    retire_t     exp_ret [$];
    logic [31:0] exp_target [$];
    logic [31:0] fetch_pc;
    logic        got_credit;
    int          n_exp;
    int          n_ret;
    int          cycles;
    int          limit;
    int          credits;
    int          pending;
    int          avail;
    int          value_errors;
    int          proto_errors;

    `include "tb_model.svh"

    core_top #(
        .queue_depth    (queue_depth),
        .retire_credits (retire_credits)
    ) i_dut (
        .clk           (clk),
        .resetn        (resetn),
        .fetch_valid   (fetch_valid),
        .fetch         (fetch),
        .fetch_credit  (fetch_credit),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .retire_credit (retire_credit),
        .redirect      (redirect)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) cycles++;

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.pc !== exp.pc) begin
            value_errors++;
            $display("FAIL retire.pc exp %h got %h", exp.pc, got.pc);
        end
        if (got.wb.we !== exp.wb.we) begin
            value_errors++;
            $display("FAIL retire.wb.we exp %h got %h at pc %h", exp.wb.we, got.wb.we, exp.pc);
        end else if (exp.wb.we && (got.wb.waddr !== exp.wb.waddr
                                   || got.wb.wdata !== exp.wb.wdata)) begin
            value_errors++;
            $display("FAIL retire.wb exp waddr %h wdata %h got waddr %h wdata %h at pc %h",
                     exp.wb.waddr, exp.wb.wdata, got.wb.waddr, got.wb.wdata, exp.pc);
        end
    endtask

    task automatic check_redirect(input redirect_t got, input redirect_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL redirect exp %h got %h", exp, got);
        end
    endtask

    task automatic build_expected();
        logic [31:0] pc;
        logic [31:0] npc;
        logic        taken;
        int          i;
        for (i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        pc = '0;
        while (pc < end_word * 4 && exp_ret.size() < 200) begin
            exp_ret.push_back(ref_exec(pc, prog[pc[31:2]], taken, npc));
            if (taken) begin
                exp_target.push_back(npc);
            end
            pc = npc;
        end
        n_exp = exp_ret.size();
    endtask

    // sender side of the fetch credit protocol
    task automatic drive_fetch();
        if (got_credit) begin
            credits++;
        end
        if (credits > queue_depth) begin
            proto_errors++;
            $display("sender holds %0d credits, more than the queue depth", credits);
        end
        if (redirect.taken) begin
            credits     = queue_depth;
            fetch_pc    = redirect.target;
            fetch_valid = 1'b0;
        end else if (credits > 0 && fetch_pc < end_word * 4 && $urandom % 4 != 0) begin
            fetch_valid = 1'b1;
            fetch       = '{pc: fetch_pc, inst: prog[fetch_pc[31:2]]};
            credits--;
            fetch_pc    = fetch_pc + 32'd4;
        end else begin
            fetch_valid = 1'b0;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        got_credit = fetch_credit;
        if (resetn) begin
            if (retire_valid) begin
                if (avail <= 0) begin
                    proto_errors++;
                    $display("retire_valid raised with no retire credit left");
                end
                avail--;
                pending++;
                n_ret++;
                if (exp_ret.size() == 0) begin
                    proto_errors++;
                    $display("more instructions retired than the program executes");
                end else begin
                    check_retire(retire, exp_ret.pop_front());
                end
            end
            if (retire_credit) begin
                avail++;
                pending--;
            end
            if (redirect.taken) begin
                if (exp_target.size() == 0) begin
                    proto_errors++;
                    $display("redirect seen where the program takes no branch");
                end else begin
                    check_redirect(redirect,
                                   redirect_t'{taken: 1'b1, target: exp_target.pop_front()});
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h159a2a94));
        resetn        = 1'b0;
        fetch_valid   = 1'b0;
        fetch         = '0;
        retire_credit = 1'b0;
        fetch_pc      = '0;
        got_credit    = 1'b0;
        cycles        = 0;
        n_ret         = 0;
        credits       = queue_depth;
        pending       = 0;
        avail         = retire_credits;
        value_errors  = 0;
        proto_errors  = 0;
        load_program();
        build_expected();
        limit = 20 * n_exp;
        repeat (4) @(posedge clk);
        #1 resetn = 1'b1;
        while (n_ret < n_exp && cycles < limit) begin
            @(posedge clk);
            #1;
            drive_fetch();
            retire_credit = (pending > 0) && ($urandom % 2 == 0);
        end
        fetch_valid   = 1'b0;
        retire_credit = 1'b0;
        if (n_ret < n_exp) begin
            proto_errors++;
            $display("timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, n_ret, n_exp);
        end
        if (exp_target.size() != 0) begin
            proto_errors++;
            $display("%0d taken branches never produced a redirect", exp_target.size());
        end
        $display("errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors + proto_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
core_pkg.sv
instr_queue.sv
decode_stage.sv
execute_stage.sv
retire_stage.sv
core_top.sv
tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_core \
    -f project.f -o sim_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0
